/* common/pid_defines.svh */
`ifndef PID_DEFINES_SVH
`define PID_DEFINES_SVH

// channel and data widths
`define PID_N_CHAN       4   // adc input channels
`define PID_W_CHAN       2   // channel index width
`define PID_W_ADC        18  // signed sample width
`define PID_W_DAC        16  // unsigned dac code width
`define PID_SHIFT        4   // right shift after the pi sum
`define PID_W_OSM        2   // oversample mode width
`define PID_QUEUE_DEPTH  8   // dac instruction queue entries

// settings after reset
`define PID_KP_INIT      10
`define PID_KI_INIT      3
`define PID_SETP_INIT    0
`define PID_OMIN_INIT    1111
`define PID_OMAX_INIT    9999
`define PID_OINIT_INIT   5000
`define PID_MULT_INIT    1

`endif

/* common/pid_cfg_pkg.sv */
package pid_cfg_pkg;
`include "pid_defines.svh"

	// axi4-lite response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [5:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;   // full words only, strobes not decoded
		logic        wvalid;
		logic        bready;
		logic [5:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
		logic        arready;
	} axil_rsp_t;

	// one routing entry, dest in the low bits, active bit above
	typedef struct packed {
		logic                   active;
		logic [`PID_W_CHAN-1:0] dest;
	} route_t;

	typedef struct packed {
		logic [`PID_W_OSM-1:0]        osm;       // average over 2^osm samples
		logic [`PID_N_CHAN-1:0]       lock_en;   // per channel pi enable
		logic signed [`PID_W_ADC-1:0] setpoint;
		logic signed [15:0]           kp;
		logic signed [15:0]           ki;
		route_t [`PID_N_CHAN-1:0]     routes;    // indexed by source channel
		logic [`PID_W_DAC-1:0]        out_min;
		logic [`PID_W_DAC-1:0]        out_max;
		logic [`PID_W_DAC-1:0]        out_init;
		logic [7:0]                   mult;      // unsigned output gain
	} pid_cfg_t;

endpackage

/* common/pid_data_pkg.sv */
package pid_data_pkg;
`include "pid_defines.svh"

	// adc sample, also the averaged value out of the oversample filter
	typedef struct packed {
		logic [`PID_W_CHAN-1:0]       chan;
		logic signed [`PID_W_ADC-1:0] data;
	} sample_t;

	// pi result of one channel
	typedef struct packed {
		logic [`PID_W_CHAN-1:0]       chan;
		logic signed [`PID_W_ADC-1:0] data;
	} ctrl_t;

	// dac update, chan is the destination dac channel
	typedef struct packed {
		logic [`PID_W_CHAN-1:0] chan;
		logic [`PID_W_DAC-1:0]  code;
	} dac_word_t;

endpackage

/* design/pid_regs.sv */
`timescale 1ns/100ps
`include "pid_defines.svh"

module pid_regs import pid_cfg_pkg::*; (
	input  logic      clk50,
	input  logic      rst_n,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output pid_cfg_t  cfg,
	input  logic      overflow   // pulse from the dac queue on a dropped word
);

	localparam logic [3:0] IDX_LAST = 4'h8;  // status word, highest mapped

	logic        wr_go;        // write address and data taken this cycle
	logic        rd_go;        // read address taken this cycle
	logic [3:0]  wr_idx;
	logic [3:0]  rd_idx;
	logic        bvalid;
	logic        rvalid;
	logic [1:0]  bresp;
	logic [1:0]  rresp;
	logic [31:0] rdata;
	logic [31:0] rd_mux;
	logic        ovf_sticky;

	assign wr_go  = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign rd_go  = axil_req.arvalid && !rvalid;
	assign wr_idx = axil_req.awaddr[5:2];   // word addressed
	assign rd_idx = axil_req.araddr[5:2];

	////////////////////////////////////////////////////////////
	// configuration registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			cfg.osm      <= '0;
			cfg.lock_en  <= '1;   // all channels locked
			cfg.setpoint <= `PID_SETP_INIT;
			cfg.kp       <= `PID_KP_INIT;
			cfg.ki       <= `PID_KI_INIT;
			cfg.out_min  <= `PID_OMIN_INIT;
			cfg.out_max  <= `PID_OMAX_INIT;
			cfg.out_init <= `PID_OINIT_INIT;
			cfg.mult     <= `PID_MULT_INIT;
			for (int i = 0; i < `PID_N_CHAN; i++) begin
				cfg.routes[i].dest   <= `PID_W_CHAN'(i);  // identity routing
				cfg.routes[i].active <= 1'b1;
			end
		end else if (wr_go) begin
			case (wr_idx)
				4'h0: begin
					cfg.osm     <= axil_req.wdata[1:0];
					cfg.lock_en <= axil_req.wdata[7:4];
				end
				4'h1: cfg.setpoint <= axil_req.wdata[`PID_W_ADC-1:0];
				4'h2: cfg.kp       <= axil_req.wdata[15:0];
				4'h3: cfg.ki       <= axil_req.wdata[15:0];
				4'h4: cfg.routes   <= axil_req.wdata[3*`PID_N_CHAN-1:0];
				4'h5: begin
					cfg.out_min <= axil_req.wdata[15:0];
					cfg.out_max <= axil_req.wdata[31:16];
				end
				4'h6: cfg.out_init <= axil_req.wdata[15:0];
				4'h7: cfg.mult     <= axil_req.wdata[7:0];
				default: ;   // status handled below, rest unmapped
			endcase
		end
	end

	// sticky overflow, a new drop wins over a clear in the same cycle
	always_ff @(posedge clk50) begin
		if (!rst_n)
			ovf_sticky <= 1'b0;
		else if (overflow)
			ovf_sticky <= 1'b1;
		else if (wr_go && wr_idx == IDX_LAST && axil_req.wdata[0])
			ovf_sticky <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// responses
	////////////////////////////////////////////////////////////

	always_comb begin
		case (rd_idx)
			4'h0:    rd_mux = {24'b0, cfg.lock_en, 2'b0, cfg.osm};
			4'h1:    rd_mux = 32'(cfg.setpoint);   // sign extended
			4'h2:    rd_mux = 32'(cfg.kp);
			4'h3:    rd_mux = 32'(cfg.ki);
			4'h4:    rd_mux = 32'(cfg.routes);
			4'h5:    rd_mux = {cfg.out_max, cfg.out_min};
			4'h6:    rd_mux = 32'(cfg.out_init);
			4'h7:    rd_mux = 32'(cfg.mult);
			4'h8:    rd_mux = {31'b0, ovf_sticky};
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_go)
				bvalid <= 1'b1;
			else if (axil_req.bready)
				bvalid <= 1'b0;
			if (rd_go)
				rvalid <= 1'b1;
			else if (axil_req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk50) begin
		if (wr_go)
			bresp <= (wr_idx > IDX_LAST) ? RESP_SLVERR : RESP_OKAY;
		if (rd_go) begin
			rdata <= rd_mux;
			rresp <= (rd_idx > IDX_LAST) ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign axil_rsp.awready = wr_go;   // both pulse together
	assign axil_rsp.wready  = wr_go;
	assign axil_rsp.bvalid  = bvalid;
	assign axil_rsp.bresp   = bresp;
	assign axil_rsp.arready = rd_go;
	assign axil_rsp.rvalid  = rvalid;
	assign axil_rsp.rdata   = rdata;
	assign axil_rsp.rresp   = rresp;

	// responses stay up, unchanged, until the host takes them
	a_bvalid_hold: assert property (@(posedge clk50) disable iff (!rst_n)
		bvalid && !axil_req.bready |=> bvalid && $stable(bresp));
	a_rvalid_hold: assert property (@(posedge clk50) disable iff (!rst_n)
		rvalid && !axil_req.rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* design/oversample_filter.sv */
`timescale 1ns/100ps
`include "pid_defines.svh"

module oversample_filter import pid_cfg_pkg::*, pid_data_pkg::*; (
	input  logic     clk50,
	input  logic     rst_n,
	input  pid_cfg_t cfg,
	input  sample_t  in_data,
	input  logic     in_valid,
	output sample_t  out_data,
	output logic     out_valid
);

	localparam int W_CNT = (1 << `PID_W_OSM) - 1;   // bits for up to 2^max_osm samples
	localparam int W_ACC = `PID_W_ADC + W_CNT;      // sum headroom

	logic signed [W_ACC-1:0] acc [`PID_N_CHAN];
	logic [W_CNT-1:0]        cnt [`PID_N_CHAN];
	logic [`PID_W_OSM-1:0]   osm_q;      // osm seen last cycle
	logic                    osm_chg;
	logic signed [W_ACC-1:0] acc_cur;
	logic signed [W_ACC-1:0] acc_sum;
	logic [W_CNT-1:0]        cnt_cur;
	logic                    last;       // this sample closes its group

	assign osm_chg = cfg.osm != osm_q;
	assign acc_cur = osm_chg ? '0 : acc[in_data.chan];   // a new osm starts fresh
	assign cnt_cur = osm_chg ? '0 : cnt[in_data.chan];
	assign acc_sum = acc_cur + in_data.data;
	assign last    = cnt_cur == W_CNT'((1 << cfg.osm) - 1);

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			osm_q     <= '0;
			out_valid <= 1'b0;
			for (int i = 0; i < `PID_N_CHAN; i++) begin
				acc[i] <= '0;
				cnt[i] <= '0;
			end
		end else begin
			osm_q     <= cfg.osm;
			out_valid <= in_valid && last;
			if (osm_chg)
				for (int i = 0; i < `PID_N_CHAN; i++) begin
					acc[i] <= '0;
					cnt[i] <= '0;
				end
			if (in_valid) begin
				acc[in_data.chan] <= last ? '0 : acc_sum;
				cnt[in_data.chan] <= last ? '0 : cnt_cur + 1'b1;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (in_valid && last) begin
			out_data.chan <= in_data.chan;
			out_data.data <= `PID_W_ADC'(acc_sum >>> cfg.osm);   // group mean
		end
	end

endmodule

/* design/pid_core.sv */
`timescale 1ns/100ps
`include "pid_defines.svh"

module pid_core import pid_cfg_pkg::*, pid_data_pkg::*; (
	input  logic     clk50,
	input  logic     rst_n,
	input  pid_cfg_t cfg,
	input  sample_t  in_data,
	input  logic     in_valid,
	output ctrl_t    out_data,
	output logic     out_valid
);

	localparam int W_ERR  = `PID_W_ADC + 1;   // setpoint minus sample
	localparam int W_PROD = 16 + W_ERR + 1;   // kp*err + ki*integ
	localparam logic signed [W_PROD-1:0] SAT_MAX = (1 <<< (`PID_W_ADC - 1)) - 1;
	localparam logic signed [W_PROD-1:0] SAT_MIN = -(1 <<< (`PID_W_ADC - 1));

	logic signed [`PID_W_ADC-1:0] integ [`PID_N_CHAN];   // one integrator per channel
	logic signed [W_ERR-1:0]      err;
	logic signed [W_ERR:0]        integ_sum;
	logic signed [`PID_W_ADC-1:0] integ_new;
	logic                         lock;
	logic                         s1_valid;
	logic [`PID_W_CHAN-1:0]       s1_chan;
	logic signed [W_ERR-1:0]      s1_err;
	logic signed [`PID_W_ADC-1:0] s1_integ;
	logic signed [W_PROD-1:0]     pi_sum;

	// clip to the 18 bit signed range
	function automatic logic signed [`PID_W_ADC-1:0] sat(input logic signed [W_PROD-1:0] x);
		if (x > SAT_MAX)
			return SAT_MAX[`PID_W_ADC-1:0];
		if (x < SAT_MIN)
			return SAT_MIN[`PID_W_ADC-1:0];
		return x[`PID_W_ADC-1:0];
	endfunction

	////////////////////////////////////////////////////////////
	// stage 1: error and integrator
	////////////////////////////////////////////////////////////

	assign lock      = cfg.lock_en[in_data.chan];
	assign err       = cfg.setpoint - in_data.data;
	assign integ_sum = integ[in_data.chan] + err;
	assign integ_new = sat(integ_sum);

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
			for (int i = 0; i < `PID_N_CHAN; i++)
				integ[i] <= '0;
		end else begin
			s1_valid  <= in_valid && lock;   // unlocked channels drop out here
			out_valid <= s1_valid;
			for (int i = 0; i < `PID_N_CHAN; i++)
				if (!cfg.lock_en[i])
					integ[i] <= '0;
			if (in_valid && lock)
				integ[in_data.chan] <= integ_new;
		end
	end

	always_ff @(posedge clk50) begin
		s1_chan  <= in_data.chan;
		s1_err   <= err;
		s1_integ <= integ_new;   // stage 2 uses the updated value
	end

	////////////////////////////////////////////////////////////
	// stage 2: weighted sum, shift, saturate
	////////////////////////////////////////////////////////////

	assign pi_sum = cfg.kp * s1_err + cfg.ki * s1_integ;

	always_ff @(posedge clk50) begin
		out_data.chan <= s1_chan;
		out_data.data <= sat(pi_sum >>> `PID_SHIFT);
	end

endmodule

/* design/output_preprocessor.sv */
`timescale 1ns/100ps
`include "pid_defines.svh"

module output_preprocessor import pid_cfg_pkg::*, pid_data_pkg::*; (
	input  logic      clk50,
	input  logic      rst_n,
	input  pid_cfg_t  cfg,
	input  ctrl_t     in_data,
	input  logic      in_valid,
	output dac_word_t out_data,
	output logic      out_valid
);

	// 18x9 bit product plus a 17 bit offset
	localparam int W_SUM = `PID_W_ADC + 10;

	route_t                  route;   // entry for the source channel
	logic signed [W_SUM-1:0] scaled;
	logic [`PID_W_DAC-1:0]   code;

	assign route  = cfg.routes[in_data.chan];
	assign scaled = in_data.data * $signed({1'b0, cfg.mult})
		+ $signed({1'b0, cfg.out_init});   // mult and init are unsigned

	// clamp into the output window, lower bound checked first
	always_comb begin
		if (scaled < $signed({1'b0, cfg.out_min}))
			code = cfg.out_min;
		else if (scaled > $signed({1'b0, cfg.out_max}))
			code = cfg.out_max;
		else
			code = scaled[`PID_W_DAC-1:0];
	end

	always_ff @(posedge clk50) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid && route.active;   // inactive route, no word
	end

	always_ff @(posedge clk50) begin
		out_data.chan <= route.dest;   // tag with the dac channel
		out_data.code <= code;
	end

endmodule

/* design/dac_instr_queue.sv */
`timescale 1ns/100ps
`include "pid_defines.svh"

module dac_instr_queue import pid_data_pkg::*; (
	input  logic      clk50,
	input  logic      rst_n,
	input  dac_word_t in_data,
	input  logic      in_valid,
	output dac_word_t out_data,
	output logic      out_valid,
	input  logic      out_ready,
	output logic      overflow
);

	localparam int DEPTH = `PID_QUEUE_DEPTH;
	localparam int W_PTR = $clog2(DEPTH);

	dac_word_t         mem [DEPTH];
	logic [W_PTR-1:0]  wr_ptr;
	logic [W_PTR-1:0]  rd_ptr;
	logic [W_PTR:0]    count;   // 0 to DEPTH entries
	logic              full;
	logic              push;
	logic              pop;

	assign full      = count == (W_PTR + 1)'(DEPTH);
	assign push      = in_valid && !full;
	assign pop       = out_valid && out_ready;
	assign overflow  = in_valid && full;   // word dropped, even if a pop frees a slot
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];        // head entry

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == W_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == W_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + push - pop;
		end
	end

	always_ff @(posedge clk50)
		if (push)
			mem[wr_ptr] <= in_data;

	// head held while the dac side stalls
	a_head_stable: assert property (@(posedge clk50) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* design/pid_controller.sv */
`timescale 1ns/100ps

module pid_controller import pid_cfg_pkg::*, pid_data_pkg::*; (
	input  logic      clk50,
	input  logic      rst_n,
	input  sample_t   sample,
	input  logic      sample_valid,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output dac_word_t dac_word,
	output logic      dac_valid,
	input  logic      dac_ready
);

	pid_cfg_t  cfg;          // settings to every stage
	sample_t   osf_data;     // channel averages
	logic      osf_valid;
	ctrl_t     pid_data;     // pi results
	logic      pid_valid;
	dac_word_t opp_data;     // scaled and routed words
	logic      opp_valid;
	logic      overflow;     // queue drop pulse

	////////////////////////////////////////////////////////////
	// host registers
	////////////////////////////////////////////////////////////

	pid_regs i_regs (
		.clk50    (clk50),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.cfg      (cfg),
		.overflow (overflow)
	);

	////////////////////////////////////////////////////////////
	// sample pipeline
	////////////////////////////////////////////////////////////

	oversample_filter i_osf (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.in_data   (sample),
		.in_valid  (sample_valid),
		.out_data  (osf_data),
		.out_valid (osf_valid)
	);

	pid_core i_pid (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.in_data   (osf_data),
		.in_valid  (osf_valid),
		.out_data  (pid_data),
		.out_valid (pid_valid)
	);

	output_preprocessor i_opp (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.in_data   (pid_data),
		.in_valid  (pid_valid),
		.out_data  (opp_data),
		.out_valid (opp_valid)
	);

	dac_instr_queue i_diq (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.in_data   (opp_data),
		.in_valid  (opp_valid),
		.out_data  (dac_word),
		.out_valid (dac_valid),
		.out_ready (dac_ready),
		.overflow  (overflow)
	);

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk50,
	output logic rst_n
);

	initial begin
		clk50 = 1'b0;
		forever #20 clk50 = ~clk50;   // 40 ns period
	end

	// reset held for 10 cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk50);
		@(negedge clk50);
		rst_n = 1'b1;
	end

endmodule

/* dv/tb_pid_controller.sv */
`timescale 1ns/100ps

module tb_pid_controller import pid_cfg_pkg::*, pid_data_pkg::*; ();

	localparam int TMO = 200;   // cycles allowed for any single wait

	logic      clk50;
	logic      rst_n;
	logic      sample_valid;
	logic      dac_valid;
	logic      dac_ready;
	sample_t   sample;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	dac_word_t dac_word;

	logic [31:0] lfsr = 32'h6916_0a1b;
	logic [17:0] exp_q [$];      // expected dac words as chan and code
	logic [17:0] exp_head;       // head of exp_q as of the falling edge
	logic        exp_any;
	int          err_cnt = 0;
	int          word_cnt = 0;
	int          aw_hs = 0;      // write requests taken by the dut
	int          ar_hs = 0;      // read requests taken by the dut
	bit          stall = 0;      // set while dac_ready is held low
	int          n_stalled;

	// model of the settings and of the channel state
	int         m_osm;
	logic [3:0] m_lock;
	longint     m_setp;
	longint     m_kp;
	longint     m_ki;
	longint     m_min;
	longint     m_max;
	longint     m_init;
	longint     m_mult;
	logic [1:0] m_dest [4];
	logic       m_act [4];
	longint     m_acc [4];
	longint     m_cnt [4];
	longint     m_integ [4];
	bit         ovf_m;

	tb_clk_gen i_clk (.clk50(clk50), .rst_n(rst_n));

	pid_controller i_dut (
		.clk50        (clk50),
		.rst_n        (rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.axil_req     (axil_req),
		.axil_rsp     (axil_rsp),
		.dac_word     (dac_word),
		.dac_valid    (dac_valid),
		.dac_ready    (dac_ready)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic longint sat18(input longint x);
		if (x > 131071)
			return 131071;
		if (x < -131072)
			return -131072;
		return x;
	endfunction

	task automatic value_err(input string msg);
		err_cnt++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic give_up(input string msg);
		$display("%s", msg);
		$display("errors %0d, dac words %0d", err_cnt, word_cnt);
		$display("STATUS: FAIL");
		$finish;
	endtask

	// readback value of register idx from the model
	function automatic logic [31:0] exp_reg(input int idx);
		logic [31:0] r;
		r = '0;
		case (idx)
			0: r = {24'b0, m_lock, 2'b0, 2'(m_osm)};
			1: r = 32'(m_setp);
			2: r = 32'(m_kp);
			3: r = 32'(m_ki);
			4: for (int i = 0; i < 4; i++) r[3*i +: 3] = {m_act[i], m_dest[i]};
			5: r = {16'(m_max), 16'(m_min)};
			6: r = 32'(m_init);
			7: r = 32'(m_mult);
			8: r = {31'b0, ovf_m};
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic apply_write(input logic [5:0] addr, input logic [31:0] d);
		case (addr[5:2])
			0: begin
				if (d[1:0] != m_osm) begin   // new osm restarts every group
					m_acc = '{default: 0};
					m_cnt = '{default: 0};
				end
				m_osm  = d[1:0];
				m_lock = d[7:4];
				for (int i = 0; i < 4; i++)
					if (!m_lock[i])
						m_integ[i] = 0;
			end
			1: m_setp = $signed(d[17:0]);
			2: m_kp   = $signed(d[15:0]);
			3: m_ki   = $signed(d[15:0]);
			4: for (int i = 0; i < 4; i++) {m_act[i], m_dest[i]} = d[3*i +: 3];
			5: begin
				m_min = d[15:0];
				m_max = d[31:16];
			end
			6: m_init = d[15:0];
			7: m_mult = d[7:0];
			8: if (d[0]) ovf_m = 0;
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// axi4-lite host
	////////////////////////////////////////////////////////////

	// accepted requests, counted at the clock edge
	always @(posedge clk50)
		if (rst_n) begin
			if (axil_rsp.awready && axil_rsp.wready)
				aw_hs++;
			if (axil_rsp.arready)
				ar_hs++;
		end

	task automatic axi_write(input logic [5:0] addr, input logic [31:0] d,
		input logic [1:0] resp);
		int n;
		int hs;
		@(negedge clk50);
		axil_req.awaddr  = addr;
		axil_req.wdata   = d;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b0;   // response left waiting a few cycles
		hs = aw_hs;
		n = 0;
		do begin
			@(posedge clk50);
			#1 n++;
		end while (!axil_rsp.bvalid && n < TMO);
		if (!axil_rsp.bvalid) begin
			give_up("timeout: no write response from the register block");
		end else begin
			@(negedge clk50);
			axil_req.awvalid = 1'b0;
			axil_req.wvalid  = 1'b0;
			for (int i = 0; i < 2; i++)
				@(negedge clk50);
			a_bresp: assert (axil_rsp.bvalid && axil_rsp.bresp == resp
				&& n == 1 && aw_hs == hs + 1)
				else value_err($sformatf("write 0x%0h gave %0b/%0d after %0d cycles %0d accepts, want %0d",
					addr, axil_rsp.bvalid, axil_rsp.bresp, n, aw_hs - hs, resp));
			axil_req.bready = 1'b1;
			if (resp == RESP_OKAY)
				apply_write(addr, d);   // unmapped writes change nothing
		end
	endtask

	task automatic axi_read(input logic [5:0] addr, input logic [31:0] d,
		input logic [1:0] resp);
		int n;
		int hs;
		@(negedge clk50);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b0;
		hs = ar_hs;
		n = 0;
		do begin
			@(posedge clk50);
			#1 n++;
		end while (!axil_rsp.rvalid && n < TMO);
		if (!axil_rsp.rvalid) begin
			give_up("timeout: no read response from the register block");
		end else begin
			@(negedge clk50);
			axil_req.arvalid = 1'b0;
			for (int i = 0; i < 2; i++)
				@(negedge clk50);
			a_rresp: assert (axil_rsp.rvalid && axil_rsp.rresp == resp && axil_rsp.rdata == d
				&& n == 1 && ar_hs == hs + 1)
				else value_err($sformatf("read 0x%0h gave %h/%0d after %0d cycles, want %h/%0d",
					addr, axil_rsp.rdata, axil_rsp.rresp, n, d, resp));
			axil_req.rready = 1'b1;
		end
	endtask

	task automatic check_regs();
		for (int i = 0; i <= 8; i++)
			axi_read(6'(4 * i), exp_reg(i), RESP_OKAY);
	endtask

	////////////////////////////////////////////////////////////
	// reference model and samples
	////////////////////////////////////////////////////////////

	task automatic predict(input int ch, input longint val);
		longint avg, e, pi, s;
		m_acc[ch] += val;
		m_cnt[ch]++;
		if (m_cnt[ch] < (1 << m_osm))
			return;   // group still open
		avg = m_acc[ch] >>> m_osm;
		m_acc[ch] = 0;
		m_cnt[ch] = 0;
		if (!m_lock[ch])
			return;
		e = m_setp - avg;
		m_integ[ch] = sat18(m_integ[ch] + e);
		pi = sat18((m_kp * e + m_ki * m_integ[ch]) >>> 4);
		if (!m_act[ch])
			return;
		s = m_init + pi * m_mult;
		if (s < m_min)
			s = m_min;
		else if (s > m_max)
			s = m_max;
		if (stall && n_stalled >= 8) begin   // word lost to a full queue
			ovf_m = 1;
			return;
		end
		if (stall)
			n_stalled++;
		exp_q.push_back({m_dest[ch], s[15:0]});
	endtask

	task automatic send_sample(input int ch, input longint val);
		@(negedge clk50);
		sample.chan  = 2'(ch);
		sample.data  = 18'(val);
		sample_valid = 1'b1;
		predict(ch, val);
	endtask

	task automatic idle();
		@(negedge clk50);
		sample_valid = 1'b0;
	endtask

	// random channels and signed data of the given width
	task automatic send_random(input int n, input int bits);
		longint v;
		for (int i = 0; i < n; i++) begin
			v = rand_bits(bits);
			send_sample(rand_bits(2), v - (longint'(1) << (bits - 1)));
		end
		idle();
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || dac_valid) && n < TMO) begin
			@(negedge clk50);
			n++;
		end
		if (exp_q.size() != 0) begin
			give_up("timeout: expected DAC words never came out");
		end else begin
			for (int i = 0; i < 8; i++)
				@(negedge clk50);   // words with no output settle
		end
	endtask

	////////////////////////////////////////////////////////////
	// scoreboard
	////////////////////////////////////////////////////////////

	// dut flops use nonblocking updates, so these are the pre-edge values
	always @(posedge clk50)
		if (rst_n && dac_valid && dac_ready && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			word_cnt++;
		end

	always @(negedge clk50) begin
		exp_any  <= exp_q.size() != 0;
		exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
	end

	a_dac_word: assert property (@(posedge clk50) disable iff (!rst_n)
		dac_valid && dac_ready |-> exp_any && dac_word == exp_head)
		else value_err($sformatf("dac word %h, expected %h (any %0b)", dac_word, exp_head, exp_any));

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic run_tests();
		int n;

		// register access with reset values, writes and an unmapped address
		check_regs();
		axi_write(6'h08, 32'h0000_1234, RESP_OKAY);
		axi_write(6'h04, 32'h0003_fffb, RESP_OKAY);   // setpoint -5
		axi_write(6'h10, 32'h0000_0e4b, RESP_OKAY);
		check_regs();
		axi_write(6'h24, 32'hffff_ffff, RESP_SLVERR);
		axi_read(6'h24, 32'h0, RESP_SLVERR);
		check_regs();

		// oversampling where pi reduces to the plain error
		axi_write(6'h10, 32'h0000_0fac, RESP_OKAY);   // identity routes
		axi_write(6'h0c, 32'h0, RESP_OKAY);
		axi_write(6'h08, 32'd16, RESP_OKAY);
		axi_write(6'h14, 32'hffff_0000, RESP_OKAY);
		axi_write(6'h18, 32'd30000, RESP_OKAY);
		axi_write(6'h04, 32'd100, RESP_OKAY);
		for (int osm = 0; osm < 4; osm++) begin
			axi_write(6'h00, 32'h0000_00f0 | osm, RESP_OKAY);
			send_random(8 << osm, 12);
			drain();
		end

		// integrator and pi saturation under large errors
		axi_write(6'h00, 32'h0000_00f0, RESP_OKAY);
		axi_write(6'h0c, 32'd3, RESP_OKAY);
		axi_write(6'h08, 32'd10, RESP_OKAY);
		axi_write(6'h18, 32'd0, RESP_OKAY);
		axi_write(6'h04, 32'd50000, RESP_OKAY);
		send_random(40, 18);
		drain();

		// clamp and remapped routes with ch2 inactive and ch1 unlocked
		axi_write(6'h0c, 32'h0, RESP_OKAY);
		axi_write(6'h08, 32'd16, RESP_OKAY);
		axi_write(6'h04, 32'd0, RESP_OKAY);
		axi_write(6'h14, {16'd2000, 16'd1000}, RESP_OKAY);
		axi_write(6'h18, 32'd1500, RESP_OKAY);
		axi_write(6'h1c, 32'd4, RESP_OKAY);
		axi_write(6'h10, 32'h0000_0877, RESP_OKAY);   // dest 3 2 1 0 by channel with ch2 off
		axi_write(6'h00, 32'h0000_00d0, RESP_OKAY);
		check_regs();
		send_random(32, 10);
		drain();

		// back-pressure with 12 words into an 8 deep queue
		axi_write(6'h00, 32'h0000_00f0, RESP_OKAY);
		axi_write(6'h10, 32'h0000_0fac, RESP_OKAY);
		axi_write(6'h14, 32'hffff_0000, RESP_OKAY);
		@(negedge clk50);
		dac_ready = 1'b0;
		stall     = 1;
		n_stalled = 0;
		for (int i = 0; i < 12; i++)
			send_sample(i % 4, 30 * i - 150);
		idle();
		for (int i = 0; i < 12; i++) @(negedge clk50);
		axi_read(6'h20, exp_reg(8), RESP_OKAY);   // overflow seen
		@(negedge clk50);
		dac_ready = 1'b1;
		stall     = 0;
		drain();
		axi_write(6'h20, 32'h1, RESP_OKAY);
		axi_read(6'h20, exp_reg(8), RESP_OKAY);

		// latency from an empty queue at osm 0
		send_sample(2, 77);
		n = 0;
		do begin
			@(negedge clk50);
			sample_valid = 1'b0;
			n++;
		end while (!dac_valid && n < 20);
		a_latency: assert (n == 5)
			else value_err($sformatf("dac_valid after %0d cycles, want 5", n));
		drain();
	endtask

	initial begin
		int n;
		sample       = '0;
		sample_valid = 1'b0;
		axil_req     = '0;
		axil_req.bready = 1'b1;
		axil_req.rready = 1'b1;
		axil_req.wstrb  = 4'hf;
		dac_ready    = 1'b1;
		exp_any      = 1'b0;
		exp_head     = '0;
		m_osm  = 0;
		m_lock = 4'hf;
		m_setp = 0;
		m_kp   = 10;
		m_ki   = 3;
		m_min  = 1111;
		m_max  = 9999;
		m_init = 5000;
		m_mult = 1;
		ovf_m  = 0;
		for (int i = 0; i < 4; i++) begin
			m_dest[i]  = 2'(i);
			m_act[i]   = 1'b1;
			m_acc[i]   = 0;
			m_cnt[i]   = 0;
			m_integ[i] = 0;
		end
		n = 0;
		while (!rst_n && n < 50) begin
			@(negedge clk50);
			n++;
		end
		if (!rst_n) begin
			give_up("timeout: reset never released");
		end else begin
			run_tests();
			$display("errors %0d, dac words %0d", err_cnt, word_cnt);
			if (err_cnt == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

/* tb.f */
+incdir+common
common/pid_cfg_pkg.sv
common/pid_data_pkg.sv
design/pid_regs.sv
design/oversample_filter.sv
design/pid_core.sv
design/output_preprocessor.sv
design/dac_instr_queue.sv
design/pid_controller.sv
dv/tb_clk_gen.sv
dv/tb_pid_controller.sv

/* Bender.yml */
package:
  name: pid_controller

sources:
  - include_dirs:
      - common
    files:
      - common/pid_cfg_pkg.sv
      - common/pid_data_pkg.sv
      - design/pid_regs.sv
      - design/oversample_filter.sv
      - design/pid_core.sv
      - design/output_preprocessor.sv
      - design/dac_instr_queue.sv
      - design/pid_controller.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_pid_controller.sv
